//--- lockin_udp_tx.f
hdl/udp_acq_pkg.sv
hdl/acq_data_pkg.sv
hdl/showahead_fifo.sv
hdl/acq_sample_framer.sv
hdl/udp_packetizer.sv
hdl/lockin_udp_tx.sv
test/tb_lockin_udp_tx.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_lockin_udp_tx -f lockin_udp_tx.f -o tb_sim \
    && ./obj_dir/tb_sim \
    || { echo "simulation run did not complete cleanly"; exit 1; }

//--- test/tb_lockin_udp_tx.sv
`timescale 1ns/1ps

module tb_lockin_udp_tx;
    import udp_acq_pkg::*;
    import acq_data_pkg::*;

    localparam int bytes_per_packet = 45;
    localparam int report_period = 600;
    localparam int timeout_cycles = 20000;    // about 9500 cycles of traffic plus margin

    logic clk;
    logic reset;
    logic sample_valid;
    lockin_sample_t sample;
    logic pml_valid;
    pml_record_t pml_record;
    logic mode_cont_disc;
    logic mode_raw_dem;
    mac_t dest_mac;
    ip_t dest_ip;
    byte_t tx_data;
    logic tx_data_write;
    logic tx_data_full;
    tx_status_t tx_status;
    logic tx_status_write;
    logic tx_status_full;
    logic leg_overflow;
    logic pml_overflow;

    lockin_sample_t leg_q[$];    // samples not yet driven
    pml_record_t pml_q[$];
    byte_t exp_bytes[$];         // payload of every packet still expected
    int exp_lens[$];
    byte_t got_bytes[$];
    int bp_mode;                 // free flow is 0, random back-pressure 1 and a held full FIFO 2
    int cycle_cnt;
    int run_cycle;               // cycles since reset release
    int leg_ovf_cnt;
    int pml_ovf_cnt;

    lockin_udp_tx #(
        .bytes_per_packet (bytes_per_packet),
        .report_period    (report_period)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_byte(input byte_t got, input byte_t exp, input int idx);
        if (got !== exp) begin
            abort_run($sformatf("error: tx_data[%0d] = 0x%h, expected 0x%h", idx, got, exp));
        end
    endtask

    task automatic compare_status(input tx_status_t got, input tx_status_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error: tx_status = 0x%h, expected 0x%h", got, exp));
        end
    endtask

    task automatic compare_overflow(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("error: %s pulses = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // expected packets for the first n queued samples, given the modes at packet start
    function automatic void model_legacy(input int n, input logic cd, input logic rd);
        lockin_sample_t s;
        freq_t cur;
        logic [63:0] dem;
        int len;
        int per_sample;
        int i;
        int k;
        per_sample = rd ? 8 : 4;
        len = 0;
        cur = '0;
        for (i = 0; i < n; i++) begin
            s = leg_q[i];
            if (len > 0 && s.freq != cur) begin    // new frequency ends a non-empty packet
                exp_lens.push_back(len);
                len = 0;
            end
            if (len == 0) begin
                exp_bytes.push_back({{4{cd}}, {4{rd}}});
                for (k = 3; k >= 0; k--) exp_bytes.push_back(s.freq[k*8 +: 8]);
                cur = s.freq;
                len = header_bytes;
            end
            if (rd) begin
                dem = {s.y, s.x};    // y goes out before x and both go MSB first
                for (k = 7; k >= 0; k--) exp_bytes.push_back(dem[k*8 +: 8]);
            end else begin
                exp_bytes.push_back(s.x[15:8]);
                exp_bytes.push_back(s.x[7:0]);
                exp_bytes.push_back(s.y[15:8]);
                exp_bytes.push_back(s.y[7:0]);
            end
            len += per_sample;
            if (len + per_sample > bytes_per_packet) begin    // next sample would not fit
                exp_lens.push_back(len);
                len = 0;
            end
        end
        if (len > 0) exp_lens.push_back(len);    // the rest leaves through the idle flush
    endfunction

    // all n records are queued before the tick, so bursts split by packet capacity
    function automatic void model_pml(input int n);
        logic [103:0] rec;
        int per_pkt;
        int in_pkt;
        int i;
        int k;
        per_pkt = bytes_per_packet / pml_record_bytes;
        in_pkt = 0;
        for (i = 0; i < n; i++) begin
            rec = {pml_q[i].nco_id, pml_q[i].freq, pml_q[i].x, pml_q[i].y};
            for (k = 12; k >= 0; k--) exp_bytes.push_back(rec[k*8 +: 8]);
            in_pkt++;
            if (in_pkt == per_pkt) begin
                exp_lens.push_back(in_pkt * pml_record_bytes);
                in_pkt = 0;
            end
        end
        if (in_pkt > 0) exp_lens.push_back(in_pkt * pml_record_bytes);
    endfunction

    task automatic make_samples(input int n, input freq_t f);
        lockin_sample_t s;
        repeat (n) begin
            s.freq = f;
            s.x = $urandom;
            s.y = $urandom;
            leg_q.push_back(s);
        end
    endtask

    task automatic make_records(input int n);
        pml_record_t r;
        repeat (n) begin
            r.spare = '0;
            r.nco_id = 8'($urandom);
            r.freq = $urandom;
            r.x = $urandom;
            r.y = $urandom;
            pml_q.push_back(r);
        end
    endtask

    task automatic send_samples(input int gap);
        while (leg_q.size() > 0) begin
            @(posedge clk);
            #1;
            sample_valid = 1'b1;
            sample = leg_q.pop_front();
            repeat (gap - 1) begin
                @(posedge clk);
                #1;
                sample_valid = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        sample_valid = 1'b0;
    endtask

    task automatic send_records();
        while (pml_q.size() > 0) begin
            @(posedge clk);
            #1;
            pml_valid = 1'b1;
            pml_record = pml_q.pop_front();
        end
        @(posedge clk);
        #1;
        pml_valid = 1'b0;
    endtask

    task automatic set_modes(input logic cd, input logic rd);
        @(posedge clk);
        #1;
        mode_cont_disc = cd;
        mode_raw_dem = rd;
    endtask

    task automatic wait_packets_done();
        while (exp_lens.size() != 0) @(posedge clk);
    endtask

    // halfway between two report ticks, so a short burst of records is never split
    task automatic wait_report_window();
        while ((run_cycle % report_period) != report_period / 2) @(posedge clk);
    endtask

    task automatic check_packet();
        int len;
        int i;
        tx_status_t exp_status;
        if (exp_lens.size() == 0) begin
            abort_run("a packet arrived when none was expected");
        end else begin
            len = exp_lens.pop_front();
            if (got_bytes.size() != len) begin
                abort_run($sformatf("packet holds %0d bytes but %0d were expected",
                                    got_bytes.size(), len));
            end else begin
                for (i = 0; i < len; i++) compare_byte(got_bytes[i], exp_bytes.pop_front(), i);
                exp_status = '{length: pkt_len_t'(len), ip: dest_ip, mac: dest_mac};
                compare_status(tx_status, exp_status);
                got_bytes.delete();
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (tx_data_write) got_bytes.push_back(tx_data);
            if (tx_status_write) check_packet();
            if (leg_overflow) leg_ovf_cnt++;
            if (pml_overflow) pml_ovf_cnt++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (!reset) run_cycle = run_cycle + 1;
        if (cycle_cnt >= timeout_cycles) begin
            abort_run("timeout: the expected packets did not all arrive in time");
        end
    end

    // the MAC side of the back-pressure
    initial begin
        tx_data_full = 1'b0;
        tx_status_full = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            case (bp_mode)
                1: begin
                    tx_data_full = ($urandom % 4) == 0;
                    tx_status_full = ($urandom % 3) == 0;
                end
                2: begin
                    tx_data_full = 1'b1;
                    tx_status_full = 1'b0;
                end
                default: begin
                    tx_data_full = 1'b0;
                    tx_status_full = 1'b0;
                end
            endcase
        end
    end

    initial begin
        void'($urandom(44));
        cycle_cnt = 0;
        run_cycle = 0;
        leg_ovf_cnt = 0;
        pml_ovf_cnt = 0;
        bp_mode = 0;
        reset = 1'b1;
        sample_valid = 1'b0;
        sample = '0;
        pml_valid = 1'b0;
        pml_record = '0;
        mode_cont_disc = 1'b1;
        mode_raw_dem = 1'b0;
        dest_mac = 48'h02_00_5e_10_20_30;
        dest_ip = 32'hc0_a8_0a_14;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        make_samples(30, 32'h0001_2345);    // three full packets in the raw layout
        model_legacy(30, 1'b1, 1'b0);
        send_samples(16);
        wait_packets_done();
        set_modes(1'b0, 1'b1);
        make_samples(10, 32'h0002_0000);
        model_legacy(10, 1'b0, 1'b1);
        send_samples(16);
        wait_packets_done();
        set_modes(1'b1, 1'b0);
        make_samples(3, 32'h0003_1000);     // frequency changes after three samples
        make_samples(10, 32'h0003_2000);
        model_legacy(13, 1'b1, 1'b0);
        send_samples(16);
        wait_packets_done();
        make_samples(4, 32'h0004_0000);     // left for the flush timer
        model_legacy(4, 1'b1, 1'b0);
        send_samples(16);
        wait_packets_done();
        make_records(5);
        model_pml(5);
        wait_report_window();
        send_records();
        wait_packets_done();

        bp_mode = 1;
        make_samples(30, 32'h0005_0000);
        model_legacy(30, 1'b1, 1'b0);
        send_samples(16);
        wait_packets_done();
        make_records(5);
        model_pml(5);
        wait_report_window();
        send_records();
        wait_packets_done();

        // nothing leaves the legacy FIFO while the data FIFO is full
        bp_mode = 2;
        repeat (2) @(posedge clk);
        compare_overflow("leg_overflow", leg_ovf_cnt, 0);
        make_samples(20, 32'h0006_0000);
        model_legacy(acq_fifo_depth, 1'b1, 1'b0);
        send_samples(1);
        repeat (4) @(posedge clk);
        compare_overflow("leg_overflow", leg_ovf_cnt, 20 - acq_fifo_depth);
        bp_mode = 0;
        wait_packets_done();
        compare_overflow("pml_overflow", pml_ovf_cnt, 0);

        // the PML FIFO only drains on report ticks, so a burst of 20 records overflows it
        make_records(20);
        model_pml(acq_fifo_depth);
        wait_report_window();
        send_records();
        repeat (4) @(posedge clk);
        compare_overflow("pml_overflow", pml_ovf_cnt, 20 - acq_fifo_depth);
        wait_packets_done();

        // a stray flush or report packet would show up within this window
        repeat (flush_idle_limit + report_period) @(posedge clk);
        if (got_bytes.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run("payload bytes arrived without a closing status");
        end
    end

endmodule

//--- hdl/lockin_udp_tx.sv
`timescale 1ns/1ps

module lockin_udp_tx #(
    parameter int bytes_per_packet = 45,
    parameter int report_period = 600
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         sample_valid,
    input  acq_data_pkg::lockin_sample_t sample,
    input  logic                         pml_valid,
    input  acq_data_pkg::pml_record_t    pml_record,
    input  logic                         mode_cont_disc,
    input  logic                         mode_raw_dem,
    input  udp_acq_pkg::mac_t            dest_mac,
    input  udp_acq_pkg::ip_t             dest_ip,
    output udp_acq_pkg::byte_t           tx_data,
    output logic                         tx_data_write,
    input  logic                         tx_data_full,
    output udp_acq_pkg::tx_status_t      tx_status,
    output logic                         tx_status_write,
    input  logic                         tx_status_full,
    output logic                         leg_overflow,
    output logic                         pml_overflow
);
    import acq_data_pkg::*;

    acq_word_t   framed_word;    // framer to legacy FIFO
    logic        framed_write;
    acq_word_t   leg_word;       // legacy FIFO head
    logic        leg_empty;
    logic        leg_rdreq;
    pml_record_t pml_word;       // PML FIFO head
    logic        pml_empty;
    logic        pml_rdreq;

    acq_sample_framer i_framer (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample       (sample),
        .word         (framed_word),
        .word_write   (framed_write)
    );

    showahead_fifo #(
        .data_width ($bits(acq_word_t)),
        .depth      (acq_fifo_depth)
    ) i_leg_fifo (
        .clk      (clk),
        .reset    (reset),
        .wdata    (framed_word),
        .write    (framed_write),
        .rdata    (leg_word),
        .rdreq    (leg_rdreq),
        .empty    (leg_empty),
        .full     (),
        .overflow (leg_overflow)
    );

    // PML records go straight into their FIFO
    showahead_fifo #(
        .data_width ($bits(pml_record_t)),
        .depth      (acq_fifo_depth)
    ) i_pml_fifo (
        .clk      (clk),
        .reset    (reset),
        .wdata    (pml_record),
        .write    (pml_valid),
        .rdata    (pml_word),
        .rdreq    (pml_rdreq),
        .empty    (pml_empty),
        .full     (),
        .overflow (pml_overflow)
    );

    udp_packetizer #(
        .bytes_per_packet (bytes_per_packet),
        .report_period    (report_period)
    ) i_packetizer (
        .clk             (clk),
        .reset           (reset),
        .mode_cont_disc  (mode_cont_disc),
        .mode_raw_dem    (mode_raw_dem),
        .dest_mac        (dest_mac),
        .dest_ip         (dest_ip),
        .leg_word        (leg_word),
        .leg_empty       (leg_empty),
        .leg_rdreq       (leg_rdreq),
        .pml_word        (pml_word),
        .pml_empty       (pml_empty),
        .pml_rdreq       (pml_rdreq),
        .tx_data         (tx_data),
        .tx_data_write   (tx_data_write),
        .tx_data_full    (tx_data_full),
        .tx_status       (tx_status),
        .tx_status_write (tx_status_write),
        .tx_status_full  (tx_status_full)
    );

endmodule

//--- hdl/udp_packetizer.sv
`timescale 1ns/1ps

module udp_packetizer #(
    parameter int bytes_per_packet = 45,
    parameter int report_period = 600
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      mode_cont_disc,
    input  logic                      mode_raw_dem,
    input  udp_acq_pkg::mac_t         dest_mac,
    input  udp_acq_pkg::ip_t          dest_ip,
    input  acq_data_pkg::acq_word_t   leg_word,
    input  logic                      leg_empty,
    output logic                      leg_rdreq,
    input  acq_data_pkg::pml_record_t pml_word,
    input  logic                      pml_empty,
    output logic                      pml_rdreq,
    output udp_acq_pkg::byte_t        tx_data,
    output logic                      tx_data_write,
    input  logic                      tx_data_full,
    output udp_acq_pkg::tx_status_t   tx_status,
    output logic                      tx_status_write,
    input  logic                      tx_status_full
);
    import udp_acq_pkg::*;

    localparam int records_per_packet = bytes_per_packet / pml_record_bytes;
    localparam int idle_cnt_w = $clog2(flush_idle_limit + 1);
    localparam int report_cnt_w = $clog2(report_period + 1);

    typedef enum logic [2:0] {
        st_idle,
        st_header_mode,
        st_header_freq,
        st_leg_wait,
        st_leg_bytes,
        st_pml_wait,
        st_pml_bytes,
        st_send_status
    } state_t;

    state_t                  state;
    pkt_len_t                byte_cnt;      // bytes written since the last status
    pkt_len_t                rec_cnt;       // PML records in the current packet
    logic [3:0]              field_cnt;     // byte index inside the current field
    logic [idle_cnt_w-1:0]   idle_cnt;      // empty cycles at a sample boundary
    logic [report_cnt_w-1:0] report_cnt;
    logic                    report_tick;
    logic                    cont_disc_q;   // modes held for the whole packet
    logic                    raw_dem_q;

    pkt_len_t    sample_bytes;
    logic [3:0]  sample_last;
    logic [63:0] dem_bytes;
    byte_t       raw_byte;
    byte_t       dem_byte;
    byte_t       pml_byte;
    byte_t       freq_byte;
    logic        leg_last;
    logic        pml_last;
    logic        room_left;
    logic        freq_break;
    logic        flush;

    assign sample_bytes = raw_dem_q ? pkt_len_t'(dem_sample_bytes) : pkt_len_t'(raw_sample_bytes);
    assign sample_last = raw_dem_q ? 4'(dem_sample_bytes - 1) : 4'(raw_sample_bytes - 1);
    assign leg_last = field_cnt == sample_last;
    assign pml_last = field_cnt == 4'(pml_record_bytes - 1);

    // the packet closes when one more sample would not fit
    assign room_left = int'(byte_cnt) + 1 + int'(sample_bytes) <= bytes_per_packet;
    // a new frequency only opens a new packet once this one holds a sample
    assign freq_break = leg_word.freq_change && (byte_cnt != pkt_len_t'(header_bytes));
    assign flush = idle_cnt == idle_cnt_w'(flush_idle_limit);

    always_comb begin
        case (field_cnt[1:0])
            2'd0: raw_byte = leg_word.x[15:8];
            2'd1: raw_byte = leg_word.x[7:0];
            2'd2: raw_byte = leg_word.y[15:8];
            default: raw_byte = leg_word.y[7:0];
        endcase
    end

    assign dem_bytes = {leg_word.y, leg_word.x};
    assign dem_byte = dem_bytes[(7 - field_cnt[2:0]) * 8 +: 8];
    assign freq_byte = leg_word.freq[(3 - field_cnt[1:0]) * 8 +: 8];
    assign pml_byte = pml_word[(12 - field_cnt) * 8 +: 8];

    // pop during the last byte so the next head is ready at the boundary
    assign leg_rdreq = (state == st_leg_bytes) && leg_last && !tx_data_full;
    assign pml_rdreq = (state == st_pml_bytes) && pml_last && !tx_data_full;

    always_ff @(posedge clk) begin
        if (reset) begin
            report_cnt <= '0;
            report_tick <= 1'b0;
        end else if (report_cnt == report_cnt_w'(report_period - 1)) begin
            report_cnt <= '0;
            report_tick <= 1'b1;
        end else begin
            report_cnt <= report_cnt + 1'b1;
            report_tick <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            idle_cnt <= '0;
        end else if (state == st_leg_wait && leg_empty) begin
            idle_cnt <= idle_cnt + 1'b1;
        end else begin
            idle_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            byte_cnt <= '0;
            rec_cnt <= '0;
            field_cnt <= '0;
            tx_data_write <= 1'b0;
            tx_status_write <= 1'b0;
        end else begin
            tx_data_write <= 1'b0;
            tx_status_write <= 1'b0;
            case (state)
                st_idle: begin
                    field_cnt <= '0;
                    if (report_tick && !pml_empty) begin    // PML report wins over legacy
                        state <= st_pml_bytes;
                    end else if (!leg_empty) begin
                        cont_disc_q <= mode_cont_disc;
                        raw_dem_q <= mode_raw_dem;
                        state <= st_header_mode;
                    end
                end
                st_header_mode: begin
                    if (!tx_data_full) begin
                        tx_data <= {{4{cont_disc_q}}, {4{raw_dem_q}}};
                        tx_data_write <= 1'b1;
                        byte_cnt <= byte_cnt + 1'b1;
                        state <= st_header_freq;
                    end
                end
                st_header_freq: begin
                    if (!tx_data_full) begin
                        tx_data <= freq_byte;
                        tx_data_write <= 1'b1;
                        byte_cnt <= byte_cnt + 1'b1;
                        field_cnt <= field_cnt + 1'b1;
                        if (field_cnt == 4'd3) begin
                            field_cnt <= '0;
                            state <= st_leg_wait;
                        end
                    end
                end
                st_leg_wait: begin
                    if (!leg_empty) begin
                        state <= freq_break ? st_send_status : st_leg_bytes;
                    end else if (flush) begin
                        state <= st_send_status;
                    end
                end
                st_leg_bytes: begin
                    if (!tx_data_full) begin
                        tx_data <= raw_dem_q ? dem_byte : raw_byte;
                        tx_data_write <= 1'b1;
                        byte_cnt <= byte_cnt + 1'b1;
                        field_cnt <= field_cnt + 1'b1;
                        if (leg_last) begin
                            field_cnt <= '0;
                            state <= room_left ? st_leg_wait : st_send_status;
                        end
                    end
                end
                st_pml_wait: begin
                    state <= pml_empty ? st_send_status : st_pml_bytes;    // buffer ran dry
                end
                st_pml_bytes: begin
                    if (!tx_data_full) begin
                        tx_data <= pml_byte;
                        tx_data_write <= 1'b1;
                        byte_cnt <= byte_cnt + 1'b1;
                        field_cnt <= field_cnt + 1'b1;
                        if (pml_last) begin
                            field_cnt <= '0;
                            rec_cnt <= rec_cnt + 1'b1;
                            if (int'(rec_cnt) + 1 >= records_per_packet) begin
                                state <= st_send_status;
                            end else begin
                                state <= st_pml_wait;
                            end
                        end
                    end
                end
                st_send_status: begin
                    if (!tx_status_full) begin
                        tx_status <= '{length: byte_cnt, ip: dest_ip, mac: dest_mac};
                        tx_status_write <= 1'b1;
                        byte_cnt <= '0;
                        rec_cnt <= '0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- hdl/acq_sample_framer.sv
`timescale 1ns/1ps

module acq_sample_framer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         sample_valid,
    input  acq_data_pkg::lockin_sample_t sample,
    output acq_data_pkg::acq_word_t      word,
    output logic                         word_write
);
    import acq_data_pkg::*;

    freq_t last_freq;     // frequency of the last framed sample
    logic  freq_known;    // low until the first sample after reset

    always_ff @(posedge clk) begin
        if (reset) begin
            word_write <= 1'b0;
            freq_known <= 1'b0;
        end else begin
            word_write <= sample_valid;    // one cycle behind the sample strobe
            if (sample_valid) begin
                freq_known <= 1'b1;
            end
        end
    end

    // payload side of the output register
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            word.spare <= '0;
            word.freq <= sample.freq;
            word.y <= sample.y;
            word.x <= sample.x;
            // the packetizer opens a new packet on this flag
            word.freq_change <= !freq_known || (sample.freq != last_freq);
            last_freq <= sample.freq;
        end
    end

endmodule

//--- hdl/showahead_fifo.sv
`timescale 1ns/1ps

module showahead_fifo #(
    parameter int data_width = 108,
    parameter int depth = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [data_width-1:0] wdata,
    input  logic                  write,
    output logic [data_width-1:0] rdata,
    input  logic                  rdreq,
    output logic                  empty,
    output logic                  full,
    output logic                  overflow
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    logic [data_width-1:0] mem [depth];
    logic [ptr_w-1:0]      wr_ptr;
    logic [ptr_w-1:0]      rd_ptr;
    logic [ptr_w:0]        count;    // number of stored words
    logic                  do_write;
    logic                  do_read;

    assign do_write = write && !full;    // a write at full is lost
    assign do_read = rdreq && !empty;

    assign empty = count == '0;
    assign full = count == (ptr_w + 1)'(depth);
    assign rdata = mem[rd_ptr];    // head is visible before it is popped

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= write && full;    // one pulse per dropped word
            if (do_write) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // pop and push in the same cycle leave the count alone
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- hdl/acq_data_pkg.sv
package acq_data_pkg;

    typedef logic signed [31:0] quad_t;    // lock-in in-phase or quadrature component
    typedef logic signed [31:0] freq_t;    // demodulation frequency word

    // one result of the lock-in amplifier
    typedef struct packed {
        freq_t freq;
        quad_t y;
        quad_t x;
    } lockin_sample_t;

    // word stored in the legacy FIFO, x in the lowest 32 bits
    typedef struct packed {
        logic [10:0] spare;
        logic        freq_change;    // set when freq differs from the previous sample
        freq_t       freq;
        quad_t       y;
        quad_t       x;
    } acq_word_t;

    // the lowest 104 bits are sent as 13 bytes, MSB first
    typedef struct packed {
        logic [3:0] spare;
        logic [7:0] nco_id;
        freq_t      freq;
        quad_t      x;
        quad_t      y;
    } pml_record_t;

    localparam int acq_fifo_depth = 16;

endpackage

//--- hdl/udp_acq_pkg.sv
package udp_acq_pkg;

    // one payload byte as it goes into the MAC transmit FIFO
    typedef logic [7:0] byte_t;

    typedef logic [47:0] mac_t;        // destination MAC address
    typedef logic [31:0] ip_t;         // destination IPv4 address
    typedef logic [15:0] pkt_len_t;    // UDP payload length in bytes

    // per-packet word for the MAC status FIFO, length ends up in the top 16 bits
    typedef struct packed {
        pkt_len_t length;
        ip_t      ip;
        mac_t     mac;
    } tx_status_t;

    // a legacy packet starts with the mode byte and the four frequency bytes
    localparam int header_bytes = 5;

    // bytes per legacy sample in each layout
    localparam int raw_sample_bytes = 4;    // x[15:0] then y[15:0]
    localparam int dem_sample_bytes = 8;    // y[31:0] then x[31:0]

    // nco id, frequency, x and y of one PML record
    localparam int pml_record_bytes = 13;

    // idle cycles at a sample boundary before a partial packet is flushed
    localparam int flush_idle_limit = 200;

endpackage
